//--- source/huff_params.svh
// ************************************************
// huffman decoder parameters
// code length limit and code table geometry
// ************************************************
`ifndef HUFF_PARAMS_SVH
`define HUFF_PARAMS_SVH

// longest legal code, also the width of the path and partial code registers
`define HUFF_MAX_CODE_LEN 16

// one table entry per possible 8-bit symbol
`define HUFF_TABLE_DEPTH 256

// address width of the code table
`define HUFF_ADDR_W 8

// number of written entries, wide enough to hold 256
`define HUFF_COUNT_W 9

`endif

//--- source/huff_pkg.sv
// ************************************************
// huffman decoder package
// code table entry layout and the FSM state types
// ************************************************
`include "huff_params.svh"

package huff_pkg;

    // one code table entry, 29 bits in total
    typedef struct packed {
        logic [7:0]                    symbol; // decoded byte value
        logic [`HUFF_MAX_CODE_LEN-1:0] code;   // right aligned so the first move sits highest
        logic [4:0]                    len;    // code length from 1 to 16
    } code_entry_t;

    typedef enum logic [2:0] {
        HDR_IDLE,      // waiting for start
        HDR_NODE,      // reading one node bit of the preorder tree
        HDR_SYMBOL,    // reading the eight symbol bits after a leaf bit
        HDR_WRITE,     // waiting for the table grant to store the leaf
        HDR_BACKTRACK, // climbing back to the next unvisited right branch
        HDR_DONE,      // tree complete so table_ready is strobed
        HDR_ERROR      // path grew beyond the longest legal code
    } hdr_state_t;

    typedef enum logic [2:0] {
        SYM_IDLE,    // waiting for table_ready
        SYM_COUNT,   // shifting in the 16-bit symbol count
        SYM_TAKE,    // appending one code bit to the partial code
        SYM_LOOKUP,  // requesting one table entry
        SYM_COMPARE, // read data is back and is checked against the partial code
        SYM_DONE     // all counted symbols are out
    } sym_state_t;

endpackage

//--- source/code_table_if.sv
// ************************************************
// code table client bus
// one client's request, command and grant toward the
// table arbiter
// ************************************************
`timescale 1ns/1ps
`include "huff_params.svh"

interface code_table_if;
    import huff_pkg::*;

    logic                    req;   // held until gnt is seen at a rising edge
    logic                    we;    // high for a write and low for a read
    logic [`HUFF_ADDR_W-1:0] addr;
    code_entry_t             wdata;
    logic                    gnt;   // combinational grant from the arbiter
    code_entry_t             rdata; // valid in the cycle after a granted read

    modport client (output req, output we, output addr, output wdata,
                    input gnt, input rdata);

    modport arbiter (input req, input we, input addr, input wdata,
                     output gnt, output rdata);

endinterface

//--- source/bit_unpacker.sv
// ************************************************
// bit unpacker
// pulls bytes from the byte source and serves them
// one bit at a time, MSB first
// ************************************************
`timescale 1ns/1ps

module bit_unpacker (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       take_header,
    input  logic       take_data,
    output logic       byte_req,
    output logic       bit_valid,
    output logic       bit_value
);

    logic [7:0] buffer;  // current byte with the next bit in bit 7
    logic [3:0] fill;    // bits left in the buffer, 0 to 8
    logic       pending; // a byte_req is out and has not been answered yet
    logic       drop;    // the outstanding answer belongs to an abandoned stream
    logic       running; // set by the first start so no request goes out after reset
    logic       take;

    assign take      = (take_header || take_data) && bit_valid;
    assign bit_valid = (fill != 4'd0);
    assign bit_value = buffer[7];
    assign byte_req  = running && !start && !bit_valid && !pending; // asks in the cycle after emptying

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill    <= 4'd0;
            pending <= 1'b0;
            drop    <= 1'b0;
            running <= 1'b0;
        end else begin
            if (start) begin
                running <= 1'b1;
                fill    <= 4'd0;                   // new stream starts on a byte boundary
                drop    <= pending && !byte_valid; // old request still in flight
            end else if (byte_valid) begin
                fill <= drop ? 4'd0 : 4'd8;
                drop <= 1'b0;
            end else if (take) begin
                fill <= fill - 4'd1;
            end
            if (byte_req) begin
                pending <= 1'b1;
            end else if (byte_valid) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            buffer <= byte_data;
        end else if (take) begin
            buffer <= {buffer[6:0], 1'b0};
        end
    end

    // the header decoder and the symbol decoder own the bit stream in turn
    assert property (@(posedge clk) disable iff (rst) !(take_header && take_data))
        else $error("both decoders took a bit in the same cycle");

endmodule

//--- source/tree_header_decoder.sv
// ************************************************
// tree header decoder
// walks the preorder tree bits and writes one code
// table entry per leaf
// ************************************************
`timescale 1ns/1ps
`include "huff_params.svh"

module tree_header_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     bit_valid,
    input  logic                     bit_value,
    output logic                     take,
    output logic                     table_ready,
    output logic                     header_error,
    output logic [`HUFF_COUNT_W-1:0] entry_count,
    code_table_if.client             tbl
);
    import huff_pkg::*;

    hdr_state_t                    state;
    logic [`HUFF_MAX_CODE_LEN-1:0] path;    // moves from the root with the newest in bit 0
    logic [4:0]                    depth;   // number of valid moves in path
    logic [2:0]                    sym_bit; // symbol bits read so far
    logic [7:0]                    symbol;

    assign take         = bit_valid && (state == HDR_NODE || state == HDR_SYMBOL);
    assign table_ready  = (state == HDR_DONE);
    assign header_error = (state == HDR_ERROR);

    // the leaf index doubles as the table address
    assign tbl.req   = (state == HDR_WRITE);
    assign tbl.we    = (state == HDR_WRITE);
    assign tbl.addr  = entry_count[`HUFF_ADDR_W-1:0];
    assign tbl.wdata = '{symbol: symbol, code: path, len: depth};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= HDR_IDLE;
            path        <= '0;
            depth       <= 5'd0;
            sym_bit     <= 3'd0;
            entry_count <= '0;
        end else if (start) begin
            state       <= HDR_NODE;
            path        <= '0;
            depth       <= 5'd0;
            sym_bit     <= 3'd0;
            entry_count <= '0; // old entries are ignored and then overwritten
        end else begin
            case (state)
                HDR_NODE: begin
                    if (take) begin
                        if (bit_value) begin
                            state   <= HDR_SYMBOL; // leaf bit and its symbol follows
                            sym_bit <= 3'd0;
                        end else if (depth == 5'(`HUFF_MAX_CODE_LEN)) begin
                            state <= HDR_ERROR; // one more left move would not fit
                        end else begin
                            path  <= {path[`HUFF_MAX_CODE_LEN-2:0], 1'b0};
                            depth <= depth + 5'd1;
                        end
                    end
                end
                HDR_SYMBOL: begin
                    if (take) begin
                        sym_bit <= sym_bit + 3'd1;
                        if (sym_bit == 3'd7) begin
                            state <= HDR_WRITE;
                        end
                    end
                end
                HDR_WRITE: begin
                    if (tbl.gnt) begin
                        entry_count <= entry_count + 1'b1;
                        state       <= HDR_BACKTRACK;
                    end
                end
                HDR_BACKTRACK: begin
                    if (depth == 5'd0) begin
                        state <= HDR_DONE; // back at the root with no left move open
                    end else if (path[0]) begin
                        path  <= path >> 1; // drop a right move
                        depth <= depth - 5'd1;
                    end else begin
                        path[0] <= 1'b1; // the sibling subtree comes next
                        state   <= HDR_NODE;
                    end
                end
                HDR_DONE, HDR_ERROR: state <= HDR_IDLE;
                default: state <= HDR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == HDR_SYMBOL && take) begin
            symbol <= {symbol[6:0], bit_value};
        end
    end

    // a tree with more leaves than table entries would wrap the leaf index onto entry 0
    assert property (@(posedge clk) disable iff (rst)
        (state == HDR_WRITE) |-> (entry_count < `HUFF_TABLE_DEPTH))
        else $error("tree header holds more leaves than the code table");

    // a leaf right at the root means a single-leaf tree which has no code
    assert property (@(posedge clk) disable iff (rst)
        (state == HDR_NODE && take && bit_value) |-> (depth != 5'd0))
        else $error("leaf at depth 0 in the tree header");

endmodule

//--- source/symbol_decoder.sv
// ************************************************
// symbol decoder
// reads the symbol count, then gathers code bits and
// matches them against the code table
// ************************************************
`timescale 1ns/1ps
`include "huff_params.svh"

module symbol_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     table_ready,
    input  logic [`HUFF_COUNT_W-1:0] entry_count,
    input  logic                     bit_valid,
    input  logic                     bit_value,
    output logic                     take,
    output logic                     sym_valid,
    output logic [7:0]               sym_data,
    output logic                     done,
    code_table_if.client             tbl
);
    import huff_pkg::*;

    sym_state_t                    state;
    logic [15:0]                   remaining; // symbols still to decode
    logic [3:0]                    count_bit; // count bits shifted in so far
    logic [`HUFF_MAX_CODE_LEN-1:0] code;      // partial code, right aligned
    logic [4:0]                    len;
    logic [`HUFF_COUNT_W-1:0]      idx;       // entry being scanned
    logic                          hit;

    assign hit       = (tbl.rdata.len == len) && (tbl.rdata.code == code);
    assign take      = bit_valid && (state == SYM_COUNT || state == SYM_TAKE);
    assign sym_valid = (state == SYM_COMPARE) && hit;
    assign sym_data  = tbl.rdata.symbol;
    assign done      = (state == SYM_DONE);

    // this client only reads
    assign tbl.req   = (state == SYM_LOOKUP);
    assign tbl.we    = 1'b0;
    assign tbl.addr  = idx[`HUFF_ADDR_W-1:0];
    assign tbl.wdata = '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= SYM_IDLE;
            remaining <= 16'd0;
            count_bit <= 4'd0;
            code      <= '0;
            len       <= 5'd0;
            idx       <= '0;
        end else begin
            case (state)
                SYM_IDLE: begin
                    if (table_ready) begin
                        state     <= SYM_COUNT;
                        count_bit <= 4'd0;
                    end
                end
                SYM_COUNT: begin
                    if (take) begin
                        remaining <= {remaining[14:0], bit_value};
                        count_bit <= count_bit + 4'd1;
                        code      <= '0;
                        len       <= 5'd0;
                        if (count_bit == 4'd15) begin
                            // an empty message ends right here
                            state <= ({remaining[14:0], bit_value} == 16'd0) ? SYM_DONE : SYM_TAKE;
                        end
                    end
                end
                SYM_TAKE: begin
                    if (take) begin
                        code  <= {code[`HUFF_MAX_CODE_LEN-2:0], bit_value};
                        len   <= len + 5'd1;
                        idx   <= '0; // every new bit rescans from entry 0
                        state <= SYM_LOOKUP;
                    end
                end
                SYM_LOOKUP: begin
                    if (tbl.gnt) begin
                        state <= SYM_COMPARE;
                    end
                end
                SYM_COMPARE: begin
                    if (hit) begin
                        remaining <= remaining - 16'd1;
                        code      <= '0;
                        len       <= 5'd0;
                        state     <= (remaining == 16'd1) ? SYM_DONE : SYM_TAKE;
                    end else if (idx + 1'b1 == entry_count) begin
                        state <= SYM_TAKE; // no entry of this length so the code needs another bit
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= SYM_LOOKUP;
                    end
                end
                SYM_DONE: state <= SYM_IDLE;
                default: state <= SYM_IDLE;
            endcase
        end
    end

    // the header decoder caps every code at 16 bits so a longer partial code is a broken stream
    assert property (@(posedge clk) disable iff (rst)
        (state == SYM_TAKE && take) |-> (len < 5'(`HUFF_MAX_CODE_LEN)))
        else $error("partial code grew beyond the longest table code");

endmodule

//--- source/code_table_arbiter.sv
// ************************************************
// code table arbiter
// fixed priority access to the table RAM with the
// header decoder first
// ************************************************
`timescale 1ns/1ps
`include "huff_params.svh"

module code_table_arbiter (
    input  logic                    clk,
    input  logic                    rst,
    code_table_if.arbiter           hdr,
    code_table_if.arbiter           sym,
    output logic                    ram_we,
    output logic [`HUFF_ADDR_W-1:0] ram_addr,
    output huff_pkg::code_entry_t   ram_wdata,
    input  huff_pkg::code_entry_t   ram_rdata
);

    logic rd_hdr; // ram output in this cycle answers the header decoder
    logic rd_sym; // ram output in this cycle answers the symbol decoder

    assign hdr.gnt = hdr.req;
    assign sym.gnt = sym.req && !hdr.req;

    assign ram_we    = hdr.gnt ? hdr.we : (sym.gnt && sym.we);
    assign ram_addr  = hdr.gnt ? hdr.addr : sym.addr;
    assign ram_wdata = hdr.gnt ? hdr.wdata : sym.wdata;

    // each client sees read data only for its own grant
    assign hdr.rdata = rd_hdr ? ram_rdata : '0;
    assign sym.rdata = rd_sym ? ram_rdata : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_hdr <= 1'b0;
            rd_sym <= 1'b0;
        end else begin
            rd_hdr <= hdr.gnt;
            rd_sym <= sym.gnt;
        end
    end

    // a symbol read that loses to the header decoder stays posted until it is granted
    assert property (@(posedge clk) disable iff (rst)
        (sym.req && !sym.gnt) |=> (sym.req && $stable(sym.addr)))
        else $error("symbol table request dropped or moved before its grant");

endmodule

//--- source/code_table_ram.sv
// ************************************************
// code table RAM
// single port table with registered read data
// ************************************************
`timescale 1ns/1ps
`include "huff_params.svh"

module code_table_ram (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`HUFF_ADDR_W-1:0] addr,
    input  huff_pkg::code_entry_t   wdata,
    output huff_pkg::code_entry_t   rdata
);
    import huff_pkg::*;

    code_entry_t mem [`HUFF_TABLE_DEPTH]; // one entry per leaf index

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // data follows one cycle after the address
    end

endmodule

//--- source/huff_decoder_top.sv
// ************************************************
// huffman stream decoder
// rebuilds the code table from the tree header and
// decodes the counted symbols that follow
// ************************************************
`timescale 1ns/1ps
`include "huff_params.svh"

module huff_decoder_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    output logic       byte_req,
    output logic       sym_valid,
    output logic [7:0] sym_data,
    output logic       table_ready,
    output logic       done,
    output logic       header_error
);
    import huff_pkg::*;

    logic                     bit_valid;
    logic                     bit_value;
    logic                     take_header;
    logic                     take_data;
    logic [`HUFF_COUNT_W-1:0] entry_count; // leaves written by the last header walk
    logic                     ram_we;
    logic [`HUFF_ADDR_W-1:0]  ram_addr;
    code_entry_t              ram_wdata;
    code_entry_t              ram_rdata;

    code_table_if hdr_tbl ();
    code_table_if sym_tbl ();

    bit_unpacker bit_unpacker_i (
        .clk(clk), .rst(rst), .start(start),
        .byte_valid(byte_valid), .byte_data(byte_data),
        .take_header(take_header), .take_data(take_data),
        .byte_req(byte_req), .bit_valid(bit_valid), .bit_value(bit_value)
    );

    tree_header_decoder tree_header_decoder_i (
        .clk(clk), .rst(rst), .start(start),
        .bit_valid(bit_valid), .bit_value(bit_value), .take(take_header),
        .table_ready(table_ready), .header_error(header_error),
        .entry_count(entry_count), .tbl(hdr_tbl.client)
    );

    symbol_decoder symbol_decoder_i (
        .clk(clk), .rst(rst), .table_ready(table_ready), .entry_count(entry_count),
        .bit_valid(bit_valid), .bit_value(bit_value), .take(take_data),
        .sym_valid(sym_valid), .sym_data(sym_data), .done(done),
        .tbl(sym_tbl.client)
    );

    code_table_arbiter code_table_arbiter_i (
        .clk(clk), .rst(rst), .hdr(hdr_tbl.arbiter), .sym(sym_tbl.arbiter),
        .ram_we(ram_we), .ram_addr(ram_addr),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    code_table_ram code_table_ram_i (
        .clk(clk), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

//--- verification/huff_decoder_tb.sv
// **************************************************
// huffman decoder testbench
// builds compressed streams from small code trees, feeds
// them through a slow byte source and checks the symbols
// **************************************************
`timescale 1ns/1ps

module huff_decoder_tb;

    logic       clk;
    logic       rst;
    logic       start;
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       byte_req;
    logic       sym_valid;
    logic [7:0] sym_data;
    logic       table_ready;
    logic       done;
    logic       header_error;

    integer      seed = 32'h50ec_d75c;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit = 20;   // grows by the budget of every stream that is built
    int          tree_tok [0:31];    // preorder tree with -1 for an internal node, else the symbol
    int          tree_n;
    logic [7:0]  msg [0:63];
    int          msg_n;
    logic [15:0] code_of [0:255];    // reference codes, right aligned
    int          len_of [0:255];
    logic        bit_q [$];          // stream under construction, one bit per entry
    logic [7:0]  stream_mem [0:255]; // all streams back to back in delivery order
    int          stream_end = 0;
    int          stream_pos = 0;     // next byte the source hands out
    logic [7:0]  exp_mem [0:255];    // expected symbols of all streams in order
    logic [7:0]  exp_sym;
    int          exp_end = 0;
    int          sym_cnt = 0;        // event counters and their expected totals
    int          tbl_cnt = 0;
    int          tbl_expect = 0;
    int          done_cnt = 0;
    int          done_expect = 0;
    int          err_cnt = 0;
    int          err_expect = 0;
    logic        outstanding = 1'b0; // a byte_req has not been answered yet

    assign exp_sym = exp_mem[sym_cnt[7:0]];

    huff_decoder_top huff_decoder_top_i (
        .clk(clk), .rst(rst), .start(start),
        .byte_valid(byte_valid), .byte_data(byte_data), .byte_req(byte_req),
        .sym_valid(sym_valid), .sym_data(sym_data), .table_ready(table_ready),
        .done(done), .header_error(header_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (byte_req) begin
            outstanding <= 1'b1;
        end else if (byte_valid) begin
            outstanding <= 1'b0;
        end
        if (sym_valid) begin
            sym_cnt <= sym_cnt + 1;
        end
        if (table_ready) begin
            tbl_cnt <= tbl_cnt + 1;
        end
        if (done) begin
            done_cnt <= done_cnt + 1;
        end
        if (header_error) begin
            err_cnt <= err_cnt + 1;
        end
    end

    // byte source that answers each request 1 to 4 cycles late
    initial begin
        int delay;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        forever begin
            @(posedge clk);
            if (byte_req) begin
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay - 1) @(posedge clk);
                #1;
                byte_valid = 1'b1;
                if (stream_pos < stream_end) begin
                    byte_data  = stream_mem[stream_pos];
                    stream_pos = stream_pos + 1;
                end else begin
                    byte_data = 8'h00; // stale request after the end of a stream
                end
                @(posedge clk);
                #1 byte_valid = 1'b0;
            end
        end
    end

    symbol_value: assert property (@(posedge clk) disable iff (rst)
        sym_valid |-> (sym_data == exp_sym))
        else begin
            errors++;
            $display("CHECK FAILED sym_data expected %02h got %02h",
                     $sampled(exp_sym), $sampled(sym_data));
        end

    symbol_extra: assert property (@(posedge clk) disable iff (rst)
        sym_valid |-> (sym_cnt < exp_end))
        else begin
            errors++;
            $display("ERROR: more symbols came out than the stream holds");
        end

    symbol_after_table: assert property (@(posedge clk) disable iff (rst)
        sym_valid |-> (tbl_cnt == tbl_expect))
        else begin
            errors++;
            $display("ERROR: symbol decoded before table_ready of its stream");
        end

    table_once: assert property (@(posedge clk) disable iff (rst)
        table_ready |-> (tbl_cnt < tbl_expect))
        else begin
            errors++;
            $display("ERROR: table_ready came twice or for a broken tree");
        end

    done_once: assert property (@(posedge clk) disable iff (rst)
        done |-> (done_cnt < done_expect) && (tbl_cnt == tbl_expect))
        else begin
            errors++;
            $display("ERROR: done came twice or before table_ready");
        end

    done_count: assert property (@(posedge clk) disable iff (rst)
        done |-> (sym_cnt == exp_end))
        else begin
            errors++;
            $display("ERROR: done after %0d symbols, the stream counts %0d",
                     $sampled(sym_cnt), $sampled(exp_end));
        end

    bytes_used: assert property (@(posedge clk) disable iff (rst)
        (done || header_error) |-> (stream_pos == stream_end))
        else begin
            errors++;
            $display("ERROR: stream ended with %0d bytes not requested",
                     $sampled(stream_end) - $sampled(stream_pos));
        end

    error_expected: assert property (@(posedge clk) disable iff (rst)
        header_error |-> (err_cnt < err_expect))
        else begin
            errors++;
            $display("ERROR: header_error raised for a legal tree");
        end

    req_single: assert property (@(posedge clk) disable iff (rst)
        byte_req |-> !outstanding)
        else begin
            errors++;
            $display("ERROR: byte_req issued while the last one was unanswered");
        end

    task automatic add_token(input int tok);
        tree_tok[tree_n] = tok;
        tree_n++;
    endtask

    task automatic push_field(input logic [15:0] value, input int width);
        for (int i = width - 1; i >= 0; i--) begin
            bit_q.push_back(value[i]); // MSB first
        end
    endtask

    // left is 0 and right is 1, a stack keeps the right children still to visit
    function automatic void derive_codes();
        logic [15:0] stk_code [0:31];
        int          stk_len [0:31];
        int          sp;
        logic [15:0] c;
        int          l;
        sp          = 1;
        stk_code[0] = 16'h0000;
        stk_len[0]  = 0;
        for (int t = 0; t < tree_n; t++) begin
            sp--;
            c = stk_code[sp];
            l = stk_len[sp];
            if (tree_tok[t] < 0) begin
                stk_code[sp]     = {c[14:0], 1'b1};
                stk_len[sp]      = l + 1;
                stk_code[sp + 1] = {c[14:0], 1'b0}; // left child is visited first
                stk_len[sp + 1]  = l + 1;
                sp += 2;
            end else begin
                code_of[tree_tok[t]] = c;
                len_of[tree_tok[t]]  = l;
            end
        end
    endfunction

    task automatic fill_message(input int n);
        logic [7:0] leaf_sym [0:31];
        int         leaf_n;
        leaf_n = 0;
        for (int t = 0; t < tree_n; t++) begin
            if (tree_tok[t] >= 0) begin
                leaf_sym[leaf_n] = 8'(tree_tok[t]);
                leaf_n++;
            end
        end
        msg_n = n;
        for (int i = 0; i < n; i++) begin
            if (i < leaf_n) begin
                msg[i] = leaf_sym[i]; // every leaf shows up at least once
            end else begin
                msg[i] = leaf_sym[$unsigned($random(seed)) % leaf_n];
            end
        end
    endtask

    // header, then the count, then the codes, padded to a whole byte
    task automatic make_stream();
        int leaves;
        int code_bits;
        leaves    = 0;
        code_bits = 0;
        bit_q.delete();
        derive_codes();
        for (int t = 0; t < tree_n; t++) begin
            if (tree_tok[t] < 0) begin
                bit_q.push_back(1'b0);
            end else begin
                bit_q.push_back(1'b1);
                push_field(16'(tree_tok[t]), 8);
                leaves++;
            end
        end
        push_field(16'(msg_n), 16);
        for (int i = 0; i < msg_n; i++) begin
            push_field(code_of[msg[i]], len_of[msg[i]]);
            code_bits += len_of[msg[i]];
            exp_mem[exp_end + i] = msg[i];
        end
        while (bit_q.size() % 8 != 0) begin
            bit_q.push_back(1'b0);
        end
        for (int b = 0; b < bit_q.size() / 8; b++) begin
            for (int k = 0; k < 8; k++) begin
                stream_mem[stream_end + b][7 - k] = bit_q[8 * b + k];
            end
        end
        stream_end  += bit_q.size() / 8;
        exp_end     += msg_n;
        tbl_expect  += 1;
        done_expect += 1;
        // every appended code bit may scan the whole table at two cycles per entry
        cycle_limit += bit_q.size() * 4 + leaves * code_bits * 2 + 100;
    endtask

    task automatic make_error_stream();
        for (int b = 0; b < 3; b++) begin
            stream_mem[stream_end + b] = 8'h00; // 17 left moves pass the 16-bit limit
        end
        stream_end  += 3;
        err_expect  += 1;
        cycle_limit += 24 * 4 + 100;
    endtask

    task automatic wait_quiet();
        repeat (8) @(posedge clk);
        while (outstanding || byte_req) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic run_stream();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        while (done_cnt != done_expect || err_cnt != err_expect) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_run();
        $display("summary: %0d symbols decoded, %0d errors", sym_cnt, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
        end
        errors++;
        $display("ERROR: stream not finished within %0d cycles", cycle_limit);
        finish_run();
    end

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        wait_quiet(); // balanced tree with four 2-bit codes
        tree_n = 0;
        add_token(-1);
        add_token(-1);
        add_token(8'h41);
        add_token(8'h42);
        add_token(-1);
        add_token(8'h43);
        add_token(8'h44);
        fill_message(20);
        make_stream();
        run_stream();

        wait_quiet(); // skewed tree with leaves at depths 1 to 8
        tree_n = 0;
        for (int d = 1; d < 8; d++) begin
            add_token(-1);
            add_token(8'h10 + d);
        end
        add_token(-1);
        add_token(8'h18);
        add_token(8'h19);
        fill_message(24);
        make_stream();
        run_stream();

        wait_quiet(); // empty message
        tree_n = 0;
        add_token(-1);
        add_token(-1);
        add_token(8'h61);
        add_token(8'h62);
        add_token(-1);
        add_token(8'h63);
        add_token(8'h64);
        fill_message(0);
        make_stream();
        run_stream();

        wait_quiet(); // left chain too deep, then a fresh table
        make_error_stream();
        run_stream();
        wait_quiet();
        tree_n = 0;
        add_token(-1);
        add_token(8'h71);
        add_token(-1);
        add_token(8'h72);
        add_token(8'h73);
        fill_message(12);
        make_stream();
        run_stream();

        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

//--- flist.f
+incdir+source
source/huff_pkg.sv
source/code_table_if.sv
source/bit_unpacker.sv
source/tree_header_decoder.sv
source/symbol_decoder.sv
source/code_table_arbiter.sv
source/code_table_ram.sv
source/huff_decoder_top.sv
verification/huff_decoder_tb.sv

//--- Bender.yml
package:
  name: huff_decoder

sources:
  - include_dirs:
      - source
    files:
      - source/huff_pkg.sv
      - source/code_table_if.sv
      - source/bit_unpacker.sv
      - source/tree_header_decoder.sv
      - source/symbol_decoder.sv
      - source/code_table_arbiter.sv
      - source/code_table_ram.sv
      - source/huff_decoder_top.sv
  - target: test
    files:
      - verification/huff_decoder_tb.sv
